// ==== common/qm_pkg.sv ====
package qm_pkg;

    ////////////////////////////////////////////////////////////
    // host register map
    ////////////////////////////////////////////////////////////

    // one host register, also the word width of every field array
    localparam int REG_SIZE = 32;

    // host byte address width
    localparam int MMIO_ADDR_WIDTH = 32;

    // each queue owns a 4 KB page, queue index starts here
    localparam int PAGE_SHIFT = 12;

    // buffer address is the high word over the low word
    localparam int BUF_ADDR_WIDTH = 2 * REG_SIZE;

    ////////////////////////////////////////////////////////////
    // field and table selects
    ////////////////////////////////////////////////////////////

    // register within a queue page, from address bits 3:2
    typedef enum logic [1:0] {
        FIELD_TAIL   = 2'd0,
        FIELD_HEAD   = 2'd1,
        FIELD_L_ADDR = 2'd2,
        FIELD_H_ADDR = 2'd3
    } q_field_t;

    // address bit just above the queue index
    typedef enum logic {
        TABLE_PKT = 1'b0,
        TABLE_DSC = 1'b1
    } table_sel_t;

    // field bits inside the byte address
    localparam int FIELD_LSB = 2;

endpackage

// ==== design/bram_true2port.sv ====
`timescale 1ns/10ps

module bram_true2port #(
    parameter int DEPTH  = 16,
    parameter int AWIDTH = 4
) (
    input  logic                        pcie_clk,
    input  logic [AWIDTH-1:0]           address_a,
    input  logic [AWIDTH-1:0]           address_b,
    input  logic [qm_pkg::REG_SIZE-1:0] data_a,
    input  logic [qm_pkg::REG_SIZE-1:0] data_b,
    input  logic                        rden_a,
    input  logic                        rden_b,
    input  logic                        wren_a,
    input  logic                        wren_b,
    output logic [qm_pkg::REG_SIZE-1:0] q_a,
    output logic [qm_pkg::REG_SIZE-1:0] q_b
);

    import qm_pkg::*;

    logic [REG_SIZE-1:0] mem [DEPTH];

    // first read stage, right out of the array
    logic [REG_SIZE-1:0] rd_a_r;
    logic [REG_SIZE-1:0] rd_b_r;

    // port a
    always_ff @(posedge pcie_clk) begin
        if (wren_a) begin
            mem[address_a] <= data_a;
        end
        if (rden_a) begin
            rd_a_r <= mem[address_a];
        end
        q_a <= rd_a_r;
    end

    // port b, same read pipeline
    always_ff @(posedge pcie_clk) begin
        if (wren_b) begin
            mem[address_b] <= data_b;
        end
        if (rden_b) begin
            rd_b_r <= mem[address_b];
        end
        q_b <= rd_b_r;
    end

endmodule

// ==== design/mmio_decoder.sv ====
`timescale 1ns/10ps

module mmio_decoder #(
    parameter int NUM_QUEUES      = 16,
    parameter int QUEUE_IDX_WIDTH = 4
) (
    input  logic                               pcie_clk,
    input  logic                               pcie_reset_n,
    input  logic [qm_pkg::MMIO_ADDR_WIDTH-1:0] mmio_address,
    input  logic                               mmio_write,
    input  logic [qm_pkg::REG_SIZE-1:0]        mmio_writedata,
    output logic                               pkt_wr_en,
    output logic                               dsc_wr_en,
    output logic [QUEUE_IDX_WIDTH-1:0]         wr_queue,
    output qm_pkg::q_field_t                   wr_field,
    output logic [qm_pkg::REG_SIZE-1:0]        wr_data,
    output logic                               head_cleared,
    output logic [QUEUE_IDX_WIDTH-1:0]         head_cleared_queue
);

    import qm_pkg::*;

    logic [QUEUE_IDX_WIDTH-1:0] page_idx;
    q_field_t                   field;
    table_sel_t                 table_sel;
    logic                       wr_ok;
    logic                       pkt_head_wr;

    ////////////////////////////////////////////////////////////
    // address split
    ////////////////////////////////////////////////////////////

    always_comb begin
        page_idx  = mmio_address[PAGE_SHIFT +: QUEUE_IDX_WIDTH];
        table_sel = table_sel_t'(mmio_address[PAGE_SHIFT + QUEUE_IDX_WIDTH]);
        field     = q_field_t'(mmio_address[FIELD_LSB +: 2]);

        // tails belong to the DMA engine, host writes to them are dropped
        wr_ok = mmio_write && (field != FIELD_TAIL) && (page_idx < NUM_QUEUES);

        pkt_head_wr = wr_ok && (table_sel == TABLE_PKT) && (field == FIELD_HEAD);
    end

    ////////////////////////////////////////////////////////////
    // registered write strobes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            pkt_wr_en    <= 1'b0;
            dsc_wr_en    <= 1'b0;
            head_cleared <= 1'b0;
        end else begin
            pkt_wr_en    <= wr_ok && (table_sel == TABLE_PKT);
            dsc_wr_en    <= wr_ok && (table_sel == TABLE_DSC);
            head_cleared <= pkt_head_wr;
        end
    end

    // payload for the port-b write
    always_ff @(posedge pcie_clk) begin
        if (wr_ok) begin
            wr_queue <= page_idx;
            wr_field <= field;
            wr_data  <= mmio_writedata;
        end
        if (pkt_head_wr) begin
            head_cleared_queue <= page_idx;
        end
    end

endmodule

// ==== queue_table/queue_table.sv ====
`timescale 1ns/10ps

module queue_table #(
    parameter int NUM_QUEUES      = 16,
    parameter int QUEUE_IDX_WIDTH = 4,
    parameter int RB_AWIDTH       = 16
) (
    input  logic                              pcie_clk,
    input  logic                              host_wr_en,
    input  logic [QUEUE_IDX_WIDTH-1:0]        host_wr_queue,
    input  qm_pkg::q_field_t                  host_wr_field,
    input  logic [qm_pkg::REG_SIZE-1:0]       host_wr_data,
    input  logic                              lookup_en,
    input  logic [QUEUE_IDX_WIDTH-1:0]        lookup_queue,
    input  logic                              tail_wr_en,
    input  logic [QUEUE_IDX_WIDTH-1:0]        tail_queue,
    input  logic [RB_AWIDTH-1:0]              new_tail,
    output logic [RB_AWIDTH-1:0]              head,
    output logic [RB_AWIDTH-1:0]              tail,
    output logic [qm_pkg::BUF_ADDR_WIDTH-1:0] buf_addr
);

    import qm_pkg::*;

    logic [QUEUE_IDX_WIDTH-1:0] tails_addr_a;
    logic [REG_SIZE-1:0]        tail_wdata;
    logic                       tail_wr_a;
    logic                       head_bypass;
    logic                       head_wr_b;
    logic                       l_addr_wr_b;
    logic                       h_addr_wr_b;

    logic [REG_SIZE-1:0] tails_q;
    logic [REG_SIZE-1:0] heads_q;
    logic [REG_SIZE-1:0] l_addrs_q;
    logic [REG_SIZE-1:0] h_addrs_q;

    // written head carried alongside the array read latency
    logic                 head_bypass_r;
    logic                 head_bypass_r2;
    logic [RB_AWIDTH-1:0] bypass_head_r;
    logic [RB_AWIDTH-1:0] bypass_head_r2;

    ////////////////////////////////////////////////////////////
    // port a steering and bypass detect
    ////////////////////////////////////////////////////////////

    always_comb begin
        // lookup owns port a, tail writes only when no lookup
        tail_wr_a    = tail_wr_en && !lookup_en;
        tails_addr_a = lookup_en ? lookup_queue : tail_queue;
        tail_wdata   = REG_SIZE'(new_tail);

        head_wr_b   = host_wr_en && (host_wr_field == FIELD_HEAD);
        l_addr_wr_b = host_wr_en && (host_wr_field == FIELD_L_ADDR);
        h_addr_wr_b = host_wr_en && (host_wr_field == FIELD_H_ADDR);

        // same queue on both ports, array read would be undefined
        head_bypass = lookup_en && head_wr_b && (host_wr_queue == lookup_queue);
    end

    always_ff @(posedge pcie_clk) begin
        head_bypass_r  <= head_bypass;
        head_bypass_r2 <= head_bypass_r;
        bypass_head_r  <= host_wr_data[RB_AWIDTH-1:0];
        bypass_head_r2 <= bypass_head_r;
    end

    always_comb begin
        head     = head_bypass_r2 ? bypass_head_r2 : heads_q[RB_AWIDTH-1:0];
        tail     = tails_q[RB_AWIDTH-1:0];
        buf_addr = {h_addrs_q, l_addrs_q};
    end

    ////////////////////////////////////////////////////////////
    // field arrays
    ////////////////////////////////////////////////////////////

    bram_true2port #(.DEPTH(NUM_QUEUES), .AWIDTH(QUEUE_IDX_WIDTH)) tails (
        .pcie_clk  (pcie_clk),
        .address_a (tails_addr_a),
        .address_b (host_wr_queue),
        .data_a    (tail_wdata),
        .data_b    (host_wr_data),
        .rden_a    (lookup_en),
        .rden_b    (1'b0),
        .wren_a    (tail_wr_a),
        .wren_b    (1'b0),
        .q_a       (tails_q),
        .q_b       ()
    );

    bram_true2port #(.DEPTH(NUM_QUEUES), .AWIDTH(QUEUE_IDX_WIDTH)) heads (
        .pcie_clk  (pcie_clk),
        .address_a (lookup_queue),
        .address_b (host_wr_queue),
        .data_a    ('0),
        .data_b    (host_wr_data),
        .rden_a    (lookup_en && !head_bypass),
        .rden_b    (1'b0),
        .wren_a    (1'b0),
        .wren_b    (head_wr_b),
        .q_a       (heads_q),
        .q_b       ()
    );

    bram_true2port #(.DEPTH(NUM_QUEUES), .AWIDTH(QUEUE_IDX_WIDTH)) l_addrs (
        .pcie_clk  (pcie_clk),
        .address_a (lookup_queue),
        .address_b (host_wr_queue),
        .data_a    ('0),
        .data_b    (host_wr_data),
        .rden_a    (lookup_en),
        .rden_b    (1'b0),
        .wren_a    (1'b0),
        .wren_b    (l_addr_wr_b),
        .q_a       (l_addrs_q),
        .q_b       ()
    );

    bram_true2port #(.DEPTH(NUM_QUEUES), .AWIDTH(QUEUE_IDX_WIDTH)) h_addrs (
        .pcie_clk  (pcie_clk),
        .address_a (lookup_queue),
        .address_b (host_wr_queue),
        .data_a    ('0),
        .data_b    (host_wr_data),
        .rden_a    (lookup_en),
        .rden_b    (1'b0),
        .wren_a    (1'b0),
        .wren_b    (h_addr_wr_b),
        .q_a       (h_addrs_q),
        .q_b       ()
    );

endmodule

// ==== design/lookup_response.sv ====
`timescale 1ns/10ps

module lookup_response #(
    parameter int NUM_QUEUES      = 16,
    parameter int QUEUE_IDX_WIDTH = 4
) (
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,
    input  logic                       lookup_en,
    input  logic [QUEUE_IDX_WIDTH-1:0] lookup_pkt_queue,
    input  logic                       head_cleared,
    input  logic [QUEUE_IDX_WIDTH-1:0] head_cleared_queue,
    output logic                       lookup_valid,
    output logic                       pkt_needs_dsc
);

    logic                       lookup_en_r;
    logic [QUEUE_IDX_WIDTH-1:0] lookup_pkt_queue_r;

    // one bit per packet queue, set once a descriptor went out
    logic [NUM_QUEUES-1:0] pkt_q_status;

    ////////////////////////////////////////////////////////////
    // valid pipeline, matches the two-cycle array read
    ////////////////////////////////////////////////////////////

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            lookup_en_r  <= 1'b0;
            lookup_valid <= 1'b0;
        end else begin
            lookup_en_r  <= lookup_en;
            lookup_valid <= lookup_en_r;
        end
    end

    always_ff @(posedge pcie_clk) begin
        lookup_pkt_queue_r <= lookup_pkt_queue;
    end

    ////////////////////////////////////////////////////////////
    // needs-descriptor tracking
    ////////////////////////////////////////////////////////////

    // test the bit one stage after the lookup
    always_ff @(posedge pcie_clk) begin
        if (lookup_en_r) begin
            pkt_needs_dsc <= !pkt_q_status[lookup_pkt_queue_r];
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            pkt_q_status <= '0;
        end else begin
            if (lookup_en_r) begin
                pkt_q_status[lookup_pkt_queue_r] <= 1'b1;
            end
            // new head from the host, next lookup sends a descriptor
            // (placed last so the clear wins on the same bit)
            if (head_cleared) begin
                pkt_q_status[head_cleared_queue] <= 1'b0;
            end
        end
    end

endmodule

// ==== design/queue_manager_top.sv ====
`timescale 1ns/10ps

module queue_manager_top #(
    parameter int NUM_QUEUES      = 16,
    parameter int QUEUE_IDX_WIDTH = 4,
    parameter int RB_AWIDTH       = 16
) (
    input  logic                               pcie_clk,
    input  logic                               pcie_reset_n,

    // host register writes
    input  logic [qm_pkg::MMIO_ADDR_WIDTH-1:0] mmio_address,
    input  logic                               mmio_write,
    input  logic [qm_pkg::REG_SIZE-1:0]        mmio_writedata,

    // DMA engine lookup and tail update
    input  logic                               lookup_en,
    input  logic [QUEUE_IDX_WIDTH-1:0]         lookup_pkt_queue,
    input  logic [QUEUE_IDX_WIDTH-1:0]         lookup_dsc_queue,
    input  logic                               tail_wr_en,
    input  logic [QUEUE_IDX_WIDTH-1:0]         tail_pkt_queue,
    input  logic [QUEUE_IDX_WIDTH-1:0]         tail_dsc_queue,
    input  logic [RB_AWIDTH-1:0]               new_pkt_tail,
    input  logic [RB_AWIDTH-1:0]               new_dsc_tail,

    // lookup results
    output logic                               lookup_valid,
    output logic [RB_AWIDTH-1:0]               pkt_head,
    output logic [RB_AWIDTH-1:0]               pkt_tail,
    output logic [RB_AWIDTH-1:0]               dsc_head,
    output logic [RB_AWIDTH-1:0]               dsc_tail,
    output logic [qm_pkg::BUF_ADDR_WIDTH-1:0]  pkt_buf_addr,
    output logic [qm_pkg::BUF_ADDR_WIDTH-1:0]  dsc_buf_addr,
    output logic                               pkt_needs_dsc
);

    import qm_pkg::*;

    // decoded host write, shared by both tables
    logic                       pkt_wr_en;
    logic                       dsc_wr_en;
    logic [QUEUE_IDX_WIDTH-1:0] wr_queue;
    q_field_t                   wr_field;
    logic [REG_SIZE-1:0]        wr_data;
    logic                       head_cleared;
    logic [QUEUE_IDX_WIDTH-1:0] head_cleared_queue;

    mmio_decoder #(
        .NUM_QUEUES      (NUM_QUEUES),
        .QUEUE_IDX_WIDTH (QUEUE_IDX_WIDTH)
    ) mmio_decoder_inst (
        .pcie_clk           (pcie_clk),
        .pcie_reset_n       (pcie_reset_n),
        .mmio_address       (mmio_address),
        .mmio_write         (mmio_write),
        .mmio_writedata     (mmio_writedata),
        .pkt_wr_en          (pkt_wr_en),
        .dsc_wr_en          (dsc_wr_en),
        .wr_queue           (wr_queue),
        .wr_field           (wr_field),
        .wr_data            (wr_data),
        .head_cleared       (head_cleared),
        .head_cleared_queue (head_cleared_queue)
    );

    ////////////////////////////////////////////////////////////
    // packet and descriptor tables
    ////////////////////////////////////////////////////////////

    queue_table #(
        .NUM_QUEUES      (NUM_QUEUES),
        .QUEUE_IDX_WIDTH (QUEUE_IDX_WIDTH),
        .RB_AWIDTH       (RB_AWIDTH)
    ) pkt_table (
        .pcie_clk      (pcie_clk),
        .host_wr_en    (pkt_wr_en),
        .host_wr_queue (wr_queue),
        .host_wr_field (wr_field),
        .host_wr_data  (wr_data),
        .lookup_en     (lookup_en),
        .lookup_queue  (lookup_pkt_queue),
        .tail_wr_en    (tail_wr_en),
        .tail_queue    (tail_pkt_queue),
        .new_tail      (new_pkt_tail),
        .head          (pkt_head),
        .tail          (pkt_tail),
        .buf_addr      (pkt_buf_addr)
    );

    queue_table #(
        .NUM_QUEUES      (NUM_QUEUES),
        .QUEUE_IDX_WIDTH (QUEUE_IDX_WIDTH),
        .RB_AWIDTH       (RB_AWIDTH)
    ) dsc_table (
        .pcie_clk      (pcie_clk),
        .host_wr_en    (dsc_wr_en),
        .host_wr_queue (wr_queue),
        .host_wr_field (wr_field),
        .host_wr_data  (wr_data),
        .lookup_en     (lookup_en),
        .lookup_queue  (lookup_dsc_queue),
        .tail_wr_en    (tail_wr_en),
        .tail_queue    (tail_dsc_queue),
        .new_tail      (new_dsc_tail),
        .head          (dsc_head),
        .tail          (dsc_tail),
        .buf_addr      (dsc_buf_addr)
    );

    lookup_response #(
        .NUM_QUEUES      (NUM_QUEUES),
        .QUEUE_IDX_WIDTH (QUEUE_IDX_WIDTH)
    ) lookup_response_inst (
        .pcie_clk           (pcie_clk),
        .pcie_reset_n       (pcie_reset_n),
        .lookup_en          (lookup_en),
        .lookup_pkt_queue   (lookup_pkt_queue),
        .head_cleared       (head_cleared),
        .head_cleared_queue (head_cleared_queue),
        .lookup_valid       (lookup_valid),
        .pkt_needs_dsc      (pkt_needs_dsc)
    );

endmodule

// ==== testbench/queue_manager_chk.sv ====
`timescale 1ns/10ps

module queue_manager_chk (
    input logic pcie_clk,
    input logic pcie_reset_n,
    input logic lookup_en,
    input logic tail_wr_en,
    input logic lookup_valid
);

    // count of failed assertions
    int fail_count = 0;

    // valid follows each lookup by exactly two cycles
    a_valid_after_lookup: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        lookup_en |-> ##2 lookup_valid)
    else begin
        $error("lookup_valid missing two cycles after lookup_en");
        fail_count++;
    end

    // and never without a lookup behind it
    a_valid_only_from_lookup: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        lookup_valid |-> $past(lookup_en, 2))
    else begin
        $error("lookup_valid high with no lookup_en two cycles before");
        fail_count++;
    end

    a_valid_low_in_reset: assert property (@(posedge pcie_clk)
        (!pcie_reset_n ##1 !pcie_reset_n) |-> !lookup_valid)
    else begin
        $error("lookup_valid high while in reset");
        fail_count++;
    end

    // port a carries either a lookup or a tail write
    a_no_lookup_with_tail: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        !(lookup_en && tail_wr_en))
    else begin
        $error("lookup_en and tail_wr_en high in the same cycle");
        fail_count++;
    end

endmodule

bind queue_manager_top queue_manager_chk chk (
    .pcie_clk     (pcie_clk),
    .pcie_reset_n (pcie_reset_n),
    .lookup_en    (lookup_en),
    .tail_wr_en   (tail_wr_en),
    .lookup_valid (lookup_valid)
);

// ==== testbench/tb_queue_manager.sv ====
`timescale 1ns/10ps

module tb_queue_manager;

    import qm_pkg::*;

    localparam int NQ            = 16;
    localparam int QW            = 4;
    localparam int DRAIN_TIMEOUT = 32;

    // expected response, captured when the lookup is issued
    typedef struct packed {
        logic        chk_fields;
        logic        needs_dsc;
        logic [15:0] pkt_head;
        logic [15:0] pkt_tail;
        logic [63:0] pkt_buf;
        logic [15:0] dsc_head;
        logic [15:0] dsc_tail;
        logic [63:0] dsc_buf;
    } expect_t;

    logic        pcie_clk;
    logic        pcie_reset_n;
    logic [31:0] mmio_address;
    logic        mmio_write;
    logic [31:0] mmio_writedata;
    logic        lookup_en;
    logic [3:0]  lookup_pkt_queue;
    logic [3:0]  lookup_dsc_queue;
    logic        tail_wr_en;
    logic [3:0]  tail_pkt_queue;
    logic [3:0]  tail_dsc_queue;
    logic [15:0] new_pkt_tail;
    logic [15:0] new_dsc_tail;
    logic        lookup_valid;
    logic [15:0] pkt_head;
    logic [15:0] pkt_tail;
    logic [15:0] dsc_head;
    logic [15:0] dsc_tail;
    logic [63:0] pkt_buf_addr;
    logic [63:0] dsc_buf_addr;
    logic        pkt_needs_dsc;

    // reference model, first index is the table
    logic [15:0] m_head  [2][NQ];
    logic [15:0] m_tail  [2][NQ];
    logic [31:0] m_laddr [2][NQ];
    logic [31:0] m_haddr [2][NQ];
    logic        m_status [NQ];

    expect_t     pending[$];
    string       cur_test;
    logic [31:0] lcg_state;
    int          errors;
    int          checks;
    int          err_base;
    int          tests_run;
    int          tests_failed;

    queue_manager_top uut (.*);

    always #4 pcie_clk = ~pcie_clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int total_errors();
        return errors + uut.chk.fail_count;
    endfunction

    // table bit sits just above the queue page index
    function automatic logic [31:0] host_addr(table_sel_t t, int q, q_field_t f);
        return (32'(t) << (PAGE_SHIFT + QW)) | (32'(q) << PAGE_SHIFT) | (32'(f) << 2);
    endfunction

    task automatic check_value(string what, logic [63:0] expected, logic [63:0] actual);
        checks++;
        assert (actual === expected)
        else begin
            $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, expected, actual);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // result monitor
    ////////////////////////////////////////////////////////////

    always @(negedge pcie_clk) begin : result_monitor
        expect_t e;
        if (pcie_reset_n && lookup_valid) begin
            if (pending.size() == 0) begin
                $display("error in %s: lookup_valid with no lookup outstanding", cur_test);
                errors++;
            end else begin
                e = pending.pop_front();
                check_value("pkt_needs_dsc", 64'(e.needs_dsc), 64'(pkt_needs_dsc));
                if (e.chk_fields) begin
                    check_value("pkt_head", 64'(e.pkt_head), 64'(pkt_head));
                    check_value("pkt_tail", 64'(e.pkt_tail), 64'(pkt_tail));
                    check_value("pkt_buf_addr", e.pkt_buf, pkt_buf_addr);
                    check_value("dsc_head", 64'(e.dsc_head), 64'(dsc_head));
                    check_value("dsc_tail", 64'(e.dsc_tail), 64'(dsc_tail));
                    check_value("dsc_buf_addr", e.dsc_buf, dsc_buf_addr);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // drivers
    ////////////////////////////////////////////////////////////

    task automatic host_write(table_sel_t t, int q, q_field_t f, logic [31:0] data);
        @(posedge pcie_clk);
        mmio_address   <= host_addr(t, q, f);
        mmio_writedata <= data;
        mmio_write     <= 1'b1;
        lookup_en      <= 1'b0;
        tail_wr_en     <= 1'b0;
        // tail writes from the host are dropped
        case (f)
            FIELD_HEAD: begin
                m_head[t][q] = data[15:0];
                if (t == TABLE_PKT) begin
                    m_status[q] = 1'b0;
                end
            end
            FIELD_L_ADDR: m_laddr[t][q] = data;
            FIELD_H_ADDR: m_haddr[t][q] = data;
            default: ;
        endcase
    endtask

    task automatic issue_lookup(int pq, int dq, logic chk);
        expect_t e;
        @(posedge pcie_clk);
        lookup_en        <= 1'b1;
        lookup_pkt_queue <= QW'(pq);
        lookup_dsc_queue <= QW'(dq);
        mmio_write       <= 1'b0;
        tail_wr_en       <= 1'b0;
        e.chk_fields = chk;
        e.needs_dsc  = !m_status[pq];
        m_status[pq] = 1'b1;
        e.pkt_head   = m_head[TABLE_PKT][pq];
        e.pkt_tail   = m_tail[TABLE_PKT][pq];
        e.pkt_buf    = {m_haddr[TABLE_PKT][pq], m_laddr[TABLE_PKT][pq]};
        e.dsc_head   = m_head[TABLE_DSC][dq];
        e.dsc_tail   = m_tail[TABLE_DSC][dq];
        e.dsc_buf    = {m_haddr[TABLE_DSC][dq], m_laddr[TABLE_DSC][dq]};
        pending.push_back(e);
    endtask

    task automatic tail_update(int pq, int dq, logic [15:0] pt, logic [15:0] dt);
        @(posedge pcie_clk);
        tail_wr_en     <= 1'b1;
        tail_pkt_queue <= QW'(pq);
        tail_dsc_queue <= QW'(dq);
        new_pkt_tail   <= pt;
        new_dsc_tail   <= dt;
        lookup_en      <= 1'b0;
        mmio_write     <= 1'b0;
        m_tail[TABLE_PKT][pq] = pt;
        m_tail[TABLE_DSC][dq] = dt;
    endtask

    task automatic release_strobes();
        @(posedge pcie_clk);
        mmio_write <= 1'b0;
        lookup_en  <= 1'b0;
        tail_wr_en <= 1'b0;
    endtask

    task automatic begin_test(string name);
        cur_test = name;
        err_base = total_errors();
        tests_run++;
    endtask

    // drain outstanding results, then report the test
    task automatic end_test();
        int n;
        release_strobes();
        n = 0;
        while (pending.size() != 0 && n < DRAIN_TIMEOUT) begin
            @(posedge pcie_clk);
            n++;
        end
        if (pending.size() != 0) begin
            $display("timeout in %s: %0d lookup results never arrived", cur_test, pending.size());
            $display("TEST FAILED");
            $finish;
        end else if (total_errors() == err_base) begin
            $display("test %-16s passed", cur_test);
        end else begin
            tests_failed++;
            $display("test %-16s failed with %0d errors", cur_test, total_errors() - err_base);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int q;
        int pq;
        int dq;
        lcg_state        = 32'hc0f9;
        pcie_clk         = 1'b0;
        pcie_reset_n     = 1'b0;
        mmio_address     = '0;
        mmio_write       = 1'b0;
        mmio_writedata   = '0;
        lookup_en        = 1'b0;
        lookup_pkt_queue = '0;
        lookup_dsc_queue = '0;
        tail_wr_en       = 1'b0;
        tail_pkt_queue   = '0;
        tail_dsc_queue   = '0;
        new_pkt_tail     = '0;
        new_dsc_tail     = '0;
        errors           = 0;
        checks           = 0;
        tests_run        = 0;
        tests_failed     = 0;
        for (int i = 0; i < NQ; i++) begin
            m_status[i] = 1'b0;
        end
        repeat (16) @(posedge pcie_clk);
        pcie_reset_n <= 1'b1;
        repeat (2) @(posedge pcie_clk);

        // fields are undefined here, only the status bit is checked
        begin_test("reset_state");
        @(negedge pcie_clk);
        check_value("lookup_valid", 64'd0, 64'(lookup_valid));
        q = next_rand() % NQ;
        issue_lookup(q, 0, 1'b0);
        issue_lookup(q, 0, 1'b0);
        end_test();

        begin_test("host_writes");
        for (int i = 0; i < NQ; i++) begin
            for (int t = 0; t < 2; t++) begin
                host_write(table_sel_t'(t), i, FIELD_HEAD, next_rand());
                host_write(table_sel_t'(t), i, FIELD_L_ADDR, next_rand());
                host_write(table_sel_t'(t), i, FIELD_H_ADDR, next_rand());
            end
            tail_update(i, i, 16'(next_rand()), 16'(next_rand()));
        end
        release_strobes();
        for (int i = 0; i < NQ; i++) begin
            issue_lookup(i, next_rand() % NQ, 1'b1);
            release_strobes();
        end
        q = next_rand() % NQ;
        host_write(TABLE_PKT, q, FIELD_TAIL, next_rand());
        host_write(TABLE_DSC, q, FIELD_TAIL, next_rand());
        release_strobes();
        issue_lookup(q, q, 1'b1);
        end_test();

        begin_test("tail_updates");
        for (int i = 0; i < 8; i++) begin
            pq = next_rand() % NQ;
            dq = next_rand() % NQ;
            tail_update(pq, dq, 16'(next_rand()), 16'(next_rand()));
            if (i % 2 == 1) begin
                release_strobes();
            end
            issue_lookup(pq, dq, 1'b1);
            release_strobes();
        end
        end_test();

        begin_test("back_to_back");
        for (int i = 0; i < 12; i++) begin
            issue_lookup(next_rand() % NQ, next_rand() % NQ, 1'b1);
        end
        end_test();

        // lookups set the bit, a packet head write clears it, a descriptor one does not
        begin_test("needs_dsc_clear");
        q = next_rand() % NQ;
        issue_lookup(q, q, 1'b1);
        release_strobes();
        issue_lookup(q, q, 1'b1);
        release_strobes();
        host_write(TABLE_PKT, q, FIELD_HEAD, next_rand());
        release_strobes();
        issue_lookup(q, q, 1'b1);
        release_strobes();
        host_write(TABLE_DSC, q, FIELD_HEAD, next_rand());
        release_strobes();
        issue_lookup(q, q, 1'b1);
        end_test();

        // lookup lands on port a in the same cycle as the port-b head write
        begin_test("head_bypass");
        for (int i = 0; i < 4; i++) begin
            q = next_rand() % NQ;
            host_write(TABLE_PKT, q, FIELD_HEAD, next_rand());
            issue_lookup(q, next_rand() % NQ, 1'b1);
            release_strobes();
            host_write(TABLE_DSC, q, FIELD_HEAD, next_rand());
            issue_lookup(next_rand() % NQ, q, 1'b1);
            release_strobes();
        end
        end_test();

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, checks, errors, uut.chk.fail_count);
        if (total_errors() == 0 && tests_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
common/qm_pkg.sv
design/bram_true2port.sv
design/mmio_decoder.sv
queue_table/queue_table.sv
design/lookup_response.sv
design/queue_manager_top.sv
testbench/queue_manager_chk.sv
testbench/tb_queue_manager.sv
